// ==== design/isu_cfg_pkg.sv ====
package isu_cfg_pkg;

    localparam int ROB_DEPTH  = 16;
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);
    // extra wrap bit for age compare
    localparam int ROB_ID_W   = ROB_IDX_W + 1;
    localparam int ISQ_DEPTH  = 8;
    localparam int ISQ_IDX_W  = $clog2(ISQ_DEPTH);
    localparam int PREG_COUNT = 64;
    localparam int PREG_W     = $clog2(PREG_COUNT);
    localparam int LREG_W     = 5;
    localparam int XLEN       = 64;
    localparam int INSTR_W    = 32;

    localparam int CX_TYPE_W     = 6;
    localparam int ALU_TYPE_W    = 11;
    localparam int MULDIV_TYPE_W = 13;
    localparam int LS_SIZE_W     = 4;
    localparam int TARGET_W      = 32;

    typedef logic [ROB_ID_W-1:0]      rob_id_t;
    typedef logic [ROB_IDX_W-1:0]     rob_idx_t;
    typedef logic [PREG_W-1:0]        preg_t;
    typedef logic [LREG_W-1:0]        lreg_t;
    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [INSTR_W-1:0]       instr_t;
    typedef logic [ISQ_IDX_W-1:0]     isq_idx_t;
    typedef logic [PREG_COUNT-1:0]    preg_mask_t;
    typedef logic [CX_TYPE_W-1:0]     cx_type_t;
    typedef logic [ALU_TYPE_W-1:0]    alu_type_t;
    typedef logic [MULDIV_TYPE_W-1:0] muldiv_type_t;
    typedef logic [LS_SIZE_W-1:0]     ls_size_t;
    typedef logic [TARGET_W-1:0]      target_t;

    // id lies 1..ROB_DEPTH-1 entries after flush_id
    function automatic logic rob_younger(rob_id_t id, rob_id_t flush_id);
        rob_id_t diff;
        diff = id - flush_id;
        return (diff != '0) && (diff < rob_id_t'(ROB_DEPTH));
    endfunction

endpackage

// ==== design/isu_uop_pkg.sv ====
package isu_uop_pkg;

    typedef struct packed {
        isu_cfg_pkg::cx_type_t     cx_type;
        logic                      is_unsigned;
        isu_cfg_pkg::alu_type_t    alu_type;
        isu_cfg_pkg::muldiv_type_t muldiv_type;
        logic                      is_word;
        logic                      is_imm;
        logic                      is_load;
        logic                      is_store;
        isu_cfg_pkg::ls_size_t     ls_size;
        logic                      predict_taken;
        isu_cfg_pkg::target_t      predict_target;
    } exu_ctrl_t;

    typedef struct packed {
        isu_cfg_pkg::xlen_t  pc;
        isu_cfg_pkg::instr_t instr;
        isu_cfg_pkg::lreg_t  lrs1;
        isu_cfg_pkg::lreg_t  lrs2;
        isu_cfg_pkg::lreg_t  lrd;
        isu_cfg_pkg::preg_t  prd;
        isu_cfg_pkg::preg_t  old_prd;
        logic                need_to_wb;
        isu_cfg_pkg::preg_t  prs1;
        isu_cfg_pkg::preg_t  prs2;
        logic                src1_is_reg;
        logic                src2_is_reg;
        isu_cfg_pkg::xlen_t  imm;
        exu_ctrl_t           ctrl;
    } disp_uop_t;

    typedef struct packed {
        isu_cfg_pkg::rob_id_t robid;
        disp_uop_t            uop;
    } issue_uop_t;

    typedef struct packed {
        logic                 valid;
        isu_cfg_pkg::rob_id_t robid;
        isu_cfg_pkg::preg_t   prd;
        logic                 need_to_wb;
        isu_cfg_pkg::xlen_t   result;
    } wb_t;

    typedef struct packed {
        isu_cfg_pkg::xlen_t   pc;
        isu_cfg_pkg::instr_t  instr;
        isu_cfg_pkg::lreg_t   lrd;
        isu_cfg_pkg::preg_t   prd;
        isu_cfg_pkg::preg_t   old_prd;
        logic                 need_to_wb;
        isu_cfg_pkg::rob_id_t robid;
    } commit_t;

    // one-hot of the register a writeback frees
    function automatic isu_cfg_pkg::preg_mask_t wb_mask(wb_t wb);
        isu_cfg_pkg::preg_mask_t mask;
        mask = '0;
        mask[wb.prd] = wb.valid && wb.need_to_wb;
        return mask;
    endfunction

endpackage

// ==== design/dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
    input  logic                    in_valid,
    input  isu_uop_pkg::disp_uop_t  in_uop,
    output logic                    in_ready,
    input  logic                    rob_can_enq,
    input  logic                    isq_can_enq,
    input  logic                    flush_valid,
    input  isu_cfg_pkg::rob_id_t    alloc_robid,
    output isu_cfg_pkg::preg_t      bt_rd_addr1,
    output isu_cfg_pkg::preg_t      bt_rd_addr2,
    input  logic                    src1_busy,
    input  logic                    src2_busy,
    output logic                    rob_enq,
    output logic                    isq_enq,
    output isu_uop_pkg::issue_uop_t isq_uop,
    output logic                    isq_src1_busy,
    output logic                    isq_src2_busy,
    output logic                    bt_alloc,
    output isu_cfg_pkg::preg_t      bt_alloc_prd
);

    logic accept;

    // no dispatch while a flush is cleaning up
    assign in_ready = rob_can_enq && isq_can_enq && !flush_valid;
    assign accept   = in_valid && in_ready;

    assign rob_enq = accept;
    assign isq_enq = accept;
    assign isq_uop = '{robid: alloc_robid, uop: in_uop};

    assign bt_rd_addr1 = in_uop.prs1;
    assign bt_rd_addr2 = in_uop.prs2;

    // immediates never wait
    assign isq_src1_busy = in_uop.src1_is_reg && src1_busy;
    assign isq_src2_busy = in_uop.src2_is_reg && src2_busy;

    assign bt_alloc     = accept && in_uop.need_to_wb;
    assign bt_alloc_prd = in_uop.prd;

endmodule

// ==== design/rob.sv ====
`timescale 1ns/1ps

module rob (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enq,
    input  isu_uop_pkg::disp_uop_t  enq_uop,
    output logic                    can_enq,
    output isu_cfg_pkg::rob_id_t    alloc_robid,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  logic                    flush_valid,
    input  isu_cfg_pkg::rob_id_t    flush_robid,
    output logic                    commit_valid,
    output isu_uop_pkg::commit_t    commit,
    output isu_cfg_pkg::preg_mask_t kill_mask
);

    isu_uop_pkg::commit_t entry [isu_cfg_pkg::ROB_DEPTH];

    logic [isu_cfg_pkg::ROB_DEPTH-1:0] valid;
    logic [isu_cfg_pkg::ROB_DEPTH-1:0] complete;
    logic [isu_cfg_pkg::ROB_DEPTH-1:0] kill;

    isu_cfg_pkg::rob_id_t  head;
    isu_cfg_pkg::rob_id_t  tail;
    isu_cfg_pkg::rob_idx_t head_idx;
    isu_cfg_pkg::rob_idx_t tail_idx;

    assign head_idx = isu_cfg_pkg::rob_idx_t'(head);
    assign tail_idx = isu_cfg_pkg::rob_idx_t'(tail);

    // full once the tail is a whole lap ahead
    assign can_enq     = (tail - head) != isu_cfg_pkg::rob_id_t'(isu_cfg_pkg::ROB_DEPTH);
    assign alloc_robid = tail;

    assign commit_valid = valid[head_idx] && complete[head_idx];
    assign commit       = entry[head_idx];

    always_comb begin
        kill      = '0;
        kill_mask = '0;
        for (int i = 0; i < isu_cfg_pkg::ROB_DEPTH; i++) begin
            kill[i] = flush_valid && valid[i]
                      && isu_cfg_pkg::rob_younger(entry[i].robid, flush_robid);
            // killed producers give their destination back
            if (kill[i] && entry[i].need_to_wb) begin
                kill_mask[entry[i].prd] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            valid    <= '0;
            complete <= '0;
        end else begin
            if (int_wb.valid) begin
                complete[isu_cfg_pkg::rob_idx_t'(int_wb.robid)] <= 1'b1;
            end
            if (mem_wb.valid) begin
                complete[isu_cfg_pkg::rob_idx_t'(mem_wb.robid)] <= 1'b1;
            end
            if (enq) begin
                valid[tail_idx]    <= 1'b1;
                complete[tail_idx] <= 1'b0;
                tail               <= tail + 1'b1;
            end
            if (commit_valid) begin
                valid[head_idx] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (flush_valid) begin
                tail <= flush_robid + 1'b1;
                for (int i = 0; i < isu_cfg_pkg::ROB_DEPTH; i++) begin
                    if (kill[i]) begin
                        valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            entry[tail_idx] <= '{
                pc:         enq_uop.pc,
                instr:      enq_uop.instr,
                lrd:        enq_uop.lrd,
                prd:        enq_uop.prd,
                old_prd:    enq_uop.old_prd,
                need_to_wb: enq_uop.need_to_wb,
                robid:      tail
            };
        end
    end

endmodule

// ==== design/busy_table.sv ====
`timescale 1ns/1ps

module busy_table (
    input  logic                    clock,
    input  logic                    reset,
    input  isu_cfg_pkg::preg_t      rd_addr1,
    input  isu_cfg_pkg::preg_t      rd_addr2,
    output logic                    busy1,
    output logic                    busy2,
    input  logic                    alloc_en,
    input  isu_cfg_pkg::preg_t      alloc_prd,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  isu_cfg_pkg::preg_mask_t kill_mask
);

    isu_cfg_pkg::preg_mask_t busy;
    isu_cfg_pkg::preg_mask_t busy_next;

    assign busy1 = busy[rd_addr1];
    assign busy2 = busy[rd_addr2];

    always_comb begin
        busy_next = busy;
        if (alloc_en) begin
            busy_next[alloc_prd] = 1'b1;
        end
        // writebacks and flushed producers both release
        busy_next = busy_next
                    & ~isu_uop_pkg::wb_mask(int_wb)
                    & ~isu_uop_pkg::wb_mask(mem_wb)
                    & ~kill_mask;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

endmodule

// ==== design/int_isq.sv ====
`timescale 1ns/1ps

module int_isq (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enq,
    input  isu_uop_pkg::issue_uop_t enq_uop,
    input  logic                    src1_busy,
    input  logic                    src2_busy,
    output logic                    can_enq,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  logic                    flush_valid,
    input  isu_cfg_pkg::rob_id_t    flush_robid,
    output logic                    issue_valid,
    output isu_uop_pkg::issue_uop_t issue_uop,
    input  logic                    issue_ready,
    output isu_cfg_pkg::preg_t      rd_addr1,
    output isu_cfg_pkg::preg_t      rd_addr2
);

    isu_uop_pkg::issue_uop_t slot [isu_cfg_pkg::ISQ_DEPTH];

    logic [isu_cfg_pkg::ISQ_DEPTH-1:0] valid;
    logic [isu_cfg_pkg::ISQ_DEPTH-1:0] rdy1;
    logic [isu_cfg_pkg::ISQ_DEPTH-1:0] rdy2;
    logic [isu_cfg_pkg::ISQ_DEPTH-1:0] killed;
    logic [isu_cfg_pkg::ISQ_DEPTH-1:0] cand;

    isu_cfg_pkg::preg_mask_t wake;
    isu_cfg_pkg::isq_idx_t   free_idx;
    isu_cfg_pkg::isq_idx_t   sel_idx;
    isu_cfg_pkg::isq_idx_t   hold_idx;
    logic                    hold;
    logic                    issue_fire;

    function automatic isu_cfg_pkg::isq_idx_t lowest_set(
        logic [isu_cfg_pkg::ISQ_DEPTH-1:0] vec
    );
        isu_cfg_pkg::isq_idx_t idx;
        idx = '0;
        for (int i = isu_cfg_pkg::ISQ_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = isu_cfg_pkg::isq_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign wake = isu_uop_pkg::wb_mask(int_wb) | isu_uop_pkg::wb_mask(mem_wb);

    always_comb begin
        for (int i = 0; i < isu_cfg_pkg::ISQ_DEPTH; i++) begin
            killed[i] = valid[i] && flush_valid
                        && isu_cfg_pkg::rob_younger(slot[i].robid, flush_robid);
            cand[i]   = valid[i] && rdy1[i] && rdy2[i] && !killed[i];
        end
    end

    assign can_enq  = !(&valid);
    assign free_idx = lowest_set(~valid);

    // a stalled pick stays put so the outputs hold steady
    assign sel_idx = (hold && cand[hold_idx]) ? hold_idx : lowest_set(cand);

    assign issue_valid = |cand;
    assign issue_uop   = slot[sel_idx];
    assign issue_fire  = issue_valid && issue_ready;
    assign rd_addr1    = issue_uop.uop.prs1;
    assign rd_addr2    = issue_uop.uop.prs2;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid    <= '0;
            rdy1     <= '0;
            rdy2     <= '0;
            hold     <= 1'b0;
            hold_idx <= '0;
        end else begin
            hold     <= issue_valid && !issue_ready;
            hold_idx <= sel_idx;
            for (int i = 0; i < isu_cfg_pkg::ISQ_DEPTH; i++) begin
                if (wake[slot[i].uop.prs1]) begin
                    rdy1[i] <= 1'b1;
                end
                if (wake[slot[i].uop.prs2]) begin
                    rdy2[i] <= 1'b1;
                end
                if (killed[i]) begin
                    valid[i] <= 1'b0;
                end
            end
            if (issue_fire) begin
                valid[sel_idx] <= 1'b0;
            end
            // writeback in the accept cycle counts as ready
            if (enq) begin
                valid[free_idx] <= 1'b1;
                rdy1[free_idx]  <= !src1_busy || wake[enq_uop.uop.prs1];
                rdy2[free_idx]  <= !src2_busy || wake[enq_uop.uop.prs2];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            slot[free_idx] <= enq_uop;
        end
    end

endmodule

// ==== design/pregfile.sv ====
`timescale 1ns/1ps

module pregfile (
    input  logic               clock,
    input  logic               reset,
    input  isu_uop_pkg::wb_t   int_wb,
    input  isu_uop_pkg::wb_t   mem_wb,
    input  isu_cfg_pkg::preg_t rd_addr1,
    input  isu_cfg_pkg::preg_t rd_addr2,
    input  logic               rd_en1,
    input  logic               rd_en2,
    output isu_cfg_pkg::xlen_t rd_data1,
    output isu_cfg_pkg::xlen_t rd_data2
);

    isu_cfg_pkg::xlen_t regs [isu_cfg_pkg::PREG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < isu_cfg_pkg::PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (int_wb.valid && int_wb.need_to_wb) begin
                regs[int_wb.prd] <= int_wb.result;
            end
            if (mem_wb.valid && mem_wb.need_to_wb) begin
                regs[mem_wb.prd] <= mem_wb.result;
            end
        end
    end

    // immediate operands read back as zero
    assign rd_data1 = rd_en1 ? regs[rd_addr1] : '0;
    assign rd_data2 = rd_en2 ? regs[rd_addr2] : '0;

endmodule

// ==== design/isu_top.sv ====
`timescale 1ns/1ps

module isu_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_valid,
    input  isu_uop_pkg::disp_uop_t  in_uop,
    output logic                    in_ready,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  logic                    flush_valid,
    input  isu_cfg_pkg::rob_id_t    flush_robid,
    output logic                    issue_valid,
    output isu_uop_pkg::issue_uop_t issue_uop,
    output isu_cfg_pkg::xlen_t      src1,
    output isu_cfg_pkg::xlen_t      src2,
    input  logic                    issue_ready,
    output logic                    commit_valid,
    output isu_uop_pkg::commit_t    commit
);

    logic                    rob_can_enq;
    logic                    isq_can_enq;
    logic                    rob_enq;
    logic                    isq_enq;
    logic                    bt_alloc;
    logic                    src1_busy;
    logic                    src2_busy;
    logic                    isq_src1_busy;
    logic                    isq_src2_busy;
    isu_cfg_pkg::rob_id_t    alloc_robid;
    isu_cfg_pkg::preg_t      bt_rd_addr1;
    isu_cfg_pkg::preg_t      bt_rd_addr2;
    isu_cfg_pkg::preg_t      bt_alloc_prd;
    isu_cfg_pkg::preg_t      prf_rd_addr1;
    isu_cfg_pkg::preg_t      prf_rd_addr2;
    isu_cfg_pkg::preg_mask_t kill_mask;
    isu_uop_pkg::issue_uop_t isq_uop;

    dispatch u_dispatch (
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_ready      (in_ready),
        .rob_can_enq   (rob_can_enq),
        .isq_can_enq   (isq_can_enq),
        .flush_valid   (flush_valid),
        .alloc_robid   (alloc_robid),
        .bt_rd_addr1   (bt_rd_addr1),
        .bt_rd_addr2   (bt_rd_addr2),
        .src1_busy     (src1_busy),
        .src2_busy     (src2_busy),
        .rob_enq       (rob_enq),
        .isq_enq       (isq_enq),
        .isq_uop       (isq_uop),
        .isq_src1_busy (isq_src1_busy),
        .isq_src2_busy (isq_src2_busy),
        .bt_alloc      (bt_alloc),
        .bt_alloc_prd  (bt_alloc_prd)
    );

    rob u_rob (
        .clock        (clock),
        .reset        (reset),
        .enq          (rob_enq),
        .enq_uop      (in_uop),
        .can_enq      (rob_can_enq),
        .alloc_robid  (alloc_robid),
        .int_wb       (int_wb),
        .mem_wb       (mem_wb),
        .flush_valid  (flush_valid),
        .flush_robid  (flush_robid),
        .commit_valid (commit_valid),
        .commit       (commit),
        .kill_mask    (kill_mask)
    );

    busy_table u_busy_table (
        .clock     (clock),
        .reset     (reset),
        .rd_addr1  (bt_rd_addr1),
        .rd_addr2  (bt_rd_addr2),
        .busy1     (src1_busy),
        .busy2     (src2_busy),
        .alloc_en  (bt_alloc),
        .alloc_prd (bt_alloc_prd),
        .int_wb    (int_wb),
        .mem_wb    (mem_wb),
        .kill_mask (kill_mask)
    );

    int_isq u_int_isq (
        .clock       (clock),
        .reset       (reset),
        .enq         (isq_enq),
        .enq_uop     (isq_uop),
        .src1_busy   (isq_src1_busy),
        .src2_busy   (isq_src2_busy),
        .can_enq     (isq_can_enq),
        .int_wb      (int_wb),
        .mem_wb      (mem_wb),
        .flush_valid (flush_valid),
        .flush_robid (flush_robid),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issue_ready (issue_ready),
        .rd_addr1    (prf_rd_addr1),
        .rd_addr2    (prf_rd_addr2)
    );

    pregfile u_pregfile (
        .clock    (clock),
        .reset    (reset),
        .int_wb   (int_wb),
        .mem_wb   (mem_wb),
        .rd_addr1 (prf_rd_addr1),
        .rd_addr2 (prf_rd_addr2),
        .rd_en1   (issue_uop.uop.src1_is_reg),
        .rd_en2   (issue_uop.uop.src2_is_reg),
        .rd_data1 (src1),
        .rd_data2 (src2)
    );

endmodule

// ==== sim/isu_vectors.svh ====
`ifndef ISU_VECTORS_SVH
`define ISU_VECTORS_SVH

localparam logic [2:0] K_DISP  = 3'd0;
localparam logic [2:0] K_INT   = 3'd1;
localparam logic [2:0] K_MEM   = 3'd2;
localparam logic [2:0] K_FLUSH = 3'd3;
localparam logic [2:0] K_FULL  = 3'd4;
localparam logic [2:0] K_DRAIN = 3'd5;
localparam logic [2:0] K_IDLE  = 3'd6;

// robid is the expected allocation for K_DISP, the target for writebacks and flushes
typedef struct packed {
    logic [2:0]           kind;
    logic                 s1;
    isu_cfg_pkg::preg_t   p1;
    logic                 s2;
    isu_cfg_pkg::preg_t   p2;
    logic                 nw;
    isu_cfg_pkg::preg_t   prd;
    isu_cfg_pkg::rob_id_t robid;
    logic                 rdy;
} step_t;

step_t steps [$];

// 32-bit Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic add(logic [2:0] kind, logic s1, int p1, logic s2, int p2,
                   logic nw, int prd, int robid, logic rdy);
    steps.push_back('{kind, s1, isu_cfg_pkg::preg_t'(p1), s2, isu_cfg_pkg::preg_t'(p2), nw,
                      isu_cfg_pkg::preg_t'(prd), isu_cfg_pkg::rob_id_t'(robid), rdy});
endtask

task automatic build_table;
    // plain uops, writebacks out of order
    add(K_DISP, 0, 0, 0, 0, 1, 1, 0, 1);
    add(K_DISP, 0, 0, 0, 0, 1, 2, 1, 1);
    add(K_DISP, 0, 0, 0, 0, 1, 3, 2, 1);
    add(K_INT,  0, 0, 0, 0, 1, 3, 2, 1);
    add(K_MEM,  0, 0, 0, 0, 1, 1, 0, 1);
    add(K_INT,  0, 0, 0, 0, 1, 2, 1, 1);
    add(K_DRAIN, 0, 0, 0, 0, 0, 0, 0, 1);
    // dependent consumers
    add(K_DISP, 0, 0, 0, 0, 1, 10, 3, 1);
    add(K_DISP, 1, 10, 0, 0, 1, 11, 4, 1);
    repeat (3) add(K_IDLE, 0, 0, 0, 0, 0, 0, 0, 1);
    add(K_MEM,  0, 0, 0, 0, 1, 10, 3, 1);
    add(K_INT,  0, 0, 0, 0, 1, 11, 4, 1);
    add(K_DISP, 0, 0, 0, 0, 1, 12, 5, 1);
    add(K_DISP, 1, 12, 1, 10, 1, 13, 6, 1);
    add(K_INT,  0, 0, 0, 0, 1, 12, 5, 1);
    add(K_INT,  0, 0, 0, 0, 1, 13, 6, 1);
    add(K_DRAIN, 0, 0, 0, 0, 0, 0, 0, 1);
    // issue back-pressure, lower slot wakes while the pick is stalled
    add(K_DISP, 0, 0, 0, 0, 1, 14, 7, 1);
    add(K_IDLE, 0, 0, 0, 0, 0, 0, 0, 1);
    add(K_DISP, 1, 14, 0, 0, 1, 15, 8, 0);
    add(K_DISP, 0, 0, 0, 0, 1, 16, 9, 0);
    add(K_MEM,  0, 0, 0, 0, 1, 14, 7, 0);
    repeat (2) add(K_IDLE, 0, 0, 0, 0, 0, 0, 0, 0);
    repeat (2) add(K_IDLE, 0, 0, 0, 0, 0, 0, 0, 1);
    add(K_INT,  0, 0, 0, 0, 1, 15, 8, 1);
    add(K_INT,  0, 0, 0, 0, 1, 16, 9, 1);
    add(K_DRAIN, 0, 0, 0, 0, 0, 0, 0, 1);
    // fill the reorder buffer
    for (int i = 0; i < 16; i++) add(K_DISP, 0, 0, 0, 0, 0, 0, 10 + i, 1);
    add(K_FULL, 0, 0, 0, 0, 0, 0, 0, 1);
    for (int i = 0; i < 16; i++) add(K_INT, 0, 0, 0, 0, 0, 0, 10 + i, 1);
    add(K_DRAIN, 0, 0, 0, 0, 0, 0, 0, 1);
    // flush kills 27 and 28, robid 27 is handed out again
    add(K_DISP, 0, 0, 0, 0, 1, 40, 26, 0);
    add(K_DISP, 0, 0, 0, 0, 1, 41, 27, 0);
    add(K_DISP, 1, 40, 0, 0, 1, 43, 28, 0);
    add(K_FLUSH, 0, 0, 0, 0, 0, 0, 26, 0);
    add(K_DISP, 1, 41, 1, 10, 1, 42, 27, 1);
    add(K_INT,  0, 0, 0, 0, 1, 40, 26, 1);
    add(K_MEM,  0, 0, 0, 0, 1, 42, 27, 1);
    add(K_DRAIN, 0, 0, 0, 0, 0, 0, 0, 1);
endtask

`endif

// ==== sim/tb_isu_top.sv ====
`timescale 1ns/1ps

module tb_isu_top;

    `include "isu_vectors.svh"

    localparam int TIMEOUT = 200;

    logic                    clock;
    logic                    reset;
    logic                    in_valid;
    isu_uop_pkg::disp_uop_t  in_uop;
    logic                    in_ready;
    isu_uop_pkg::wb_t        int_wb;
    isu_uop_pkg::wb_t        mem_wb;
    logic                    flush_valid;
    isu_cfg_pkg::rob_id_t    flush_robid;
    logic                    issue_valid;
    isu_uop_pkg::issue_uop_t issue_uop;
    isu_cfg_pkg::xlen_t      src1;
    isu_cfg_pkg::xlen_t      src2;
    logic                    issue_ready;
    logic                    commit_valid;
    isu_uop_pkg::commit_t    commit;

    // reference model
    isu_uop_pkg::disp_uop_t  uop_tab [32];
    logic [31:0]             live;
    logic [31:0]             done;
    logic [31:0]             issued;
    logic [63:0]             busy;
    isu_cfg_pkg::xlen_t      shadow [64];
    isu_cfg_pkg::rob_id_t    m_head;
    isu_cfg_pkg::rob_id_t    m_tail;
    isu_cfg_pkg::rob_id_t    exp_alloc;
    int                      isq_cnt;
    logic                    hold_prev;
    isu_uop_pkg::issue_uop_t held_uop;
    isu_cfg_pkg::xlen_t      held_src1;
    isu_cfg_pkg::xlen_t      held_src2;
    logic [31:0]             lfsr;

    isu_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_uop       (in_uop),
        .in_ready     (in_ready),
        .int_wb       (int_wb),
        .mem_wb       (mem_wb),
        .flush_valid  (flush_valid),
        .flush_robid  (flush_robid),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .src1         (src1),
        .src2         (src2),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run("flag mismatch");
        end
    endtask

    task automatic check_value(string name, isu_cfg_pkg::xlen_t got, isu_cfg_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    task automatic check_issue(isu_uop_pkg::issue_uop_t got, isu_uop_pkg::issue_uop_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: issue_uop is %h, expected %h", $time, got, exp);
            stop_run("issued micro-op mismatch");
        end
    endtask

    task automatic check_commit(isu_uop_pkg::commit_t got, isu_uop_pkg::commit_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: commit is %h, expected %h", $time, got, exp);
            stop_run("committed micro-op mismatch");
        end
    endtask

    function automatic logic [319:0] rand_bits(int n);
        logic [319:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[318:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic is_younger(isu_cfg_pkg::rob_id_t id, isu_cfg_pkg::rob_id_t f);
        logic [4:0] diff;
        diff = id - f;
        return (diff >= 5'd1) && (diff <= 5'd15);
    endfunction

    task automatic apply_wb(isu_uop_pkg::wb_t wb);
        if (wb.valid) begin
            done[wb.robid] = 1'b1;
            if (wb.need_to_wb) begin
                shadow[wb.prd] = wb.result;
                busy[wb.prd]   = 1'b0;
            end
        end
    endtask

    // check outputs against the model, then step the model past the coming edge
    task automatic observe;
        isu_cfg_pkg::rob_id_t    r;
        isu_cfg_pkg::rob_id_t    id;
        isu_uop_pkg::disp_uop_t  u;
        isu_uop_pkg::issue_uop_t exp_issue;
        isu_uop_pkg::commit_t    exp_commit;
        r = issue_uop.robid;
        check_flag("in_ready", in_ready,
                   (m_tail - m_head) != 5'd16 && isq_cnt < 8 && !flush_valid);
        if (hold_prev) begin
            check_flag("issue_valid", issue_valid, 1'b1);
            check_issue(issue_uop, held_uop);
            check_value("src1", src1, held_src1);
            check_value("src2", src2, held_src2);
        end
        if (issue_valid) begin
            if (!live[r] || issued[r]) begin
                stop_run("issued a robid that is not waiting to issue");
            end
            u = uop_tab[r];
            exp_issue = '{robid: r, uop: u};
            check_issue(issue_uop, exp_issue);
            if (u.src1_is_reg && busy[u.prs1]) stop_run("source 1 issued before its writeback");
            if (u.src2_is_reg && busy[u.prs2]) stop_run("source 2 issued before its writeback");
            check_value("src1", src1, u.src1_is_reg ? shadow[u.prs1] : '0);
            check_value("src2", src2, u.src2_is_reg ? shadow[u.prs2] : '0);
        end
        if (commit_valid) begin
            if (!live[m_head] || !done[m_head]) stop_run("commit of an incomplete entry");
            u = uop_tab[m_head];
            exp_commit = '{pc: u.pc, instr: u.instr, lrd: u.lrd, prd: u.prd,
                           old_prd: u.old_prd, need_to_wb: u.need_to_wb, robid: m_head};
            check_commit(commit, exp_commit);
        end
        hold_prev = issue_valid && !issue_ready && !flush_valid;
        held_uop  = issue_uop;
        held_src1 = src1;
        held_src2 = src2;
        // the table's robid decides where the DUT must report this uop
        if (in_valid && in_ready) begin
            uop_tab[exp_alloc] = in_uop;
            live[exp_alloc]    = 1'b1;
            done[exp_alloc]    = 1'b0;
            issued[exp_alloc]  = 1'b0;
            if (in_uop.need_to_wb) busy[in_uop.prd] = 1'b1;
            m_tail  = m_tail + 1'b1;
            isq_cnt = isq_cnt + 1;
        end
        if (issue_valid && issue_ready) begin
            issued[r] = 1'b1;
            isq_cnt   = isq_cnt - 1;
        end
        if (commit_valid) begin
            live[m_head] = 1'b0;
            m_head       = m_head + 1'b1;
        end
        apply_wb(int_wb);
        apply_wb(mem_wb);
        if (flush_valid) begin
            for (int i = 0; i < 32; i++) begin
                id = isu_cfg_pkg::rob_id_t'(i);
                if (live[i] && is_younger(id, flush_robid)) begin
                    live[i] = 1'b0;
                    if (!issued[i]) isq_cnt = isq_cnt - 1;
                    if (uop_tab[i].need_to_wb) busy[uop_tab[i].prd] = 1'b0;
                end
            end
            m_tail = flush_robid + 1'b1;
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            observe();
        end
    end

    task automatic wait_accept;
        int n;
        n = 0;
        forever begin
            @(negedge clock);
            if (in_ready) break;
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for in_ready");
        end
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        forever begin
            // model is stepped on the falling edge
            @(posedge clock);
            if (m_head == m_tail && isq_cnt == 0) break;
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for issue and commit to drain");
        end
    endtask

    task automatic run_step(step_t s);
        isu_uop_pkg::disp_uop_t u;
        isu_uop_pkg::wb_t       wb;
        logic [319:0]           bits;
        @(posedge clock);
        in_valid    <= 1'b0;
        int_wb      <= '0;
        mem_wb      <= '0;
        flush_valid <= 1'b0;
        issue_ready <= s.rdy;
        case (s.kind)
            K_DISP: begin
                bits = rand_bits($bits(u));
                u = bits[$bits(u)-1:0];
                u.src1_is_reg = s.s1;
                u.prs1        = s.p1;
                u.src2_is_reg = s.s2;
                u.prs2        = s.p2;
                u.need_to_wb  = s.nw;
                u.prd         = s.prd;
                exp_alloc = s.robid;
                in_valid <= 1'b1;
                in_uop   <= u;
                wait_accept();
            end
            K_INT, K_MEM: begin
                bits = rand_bits(64);
                wb = '{valid: 1'b1, robid: s.robid, prd: s.prd, need_to_wb: s.nw,
                       result: bits[63:0]};
                if (s.kind == K_INT) int_wb <= wb;
                else mem_wb <= wb;
            end
            K_FLUSH: begin
                flush_valid <= 1'b1;
                flush_robid <= s.robid;
            end
            K_FULL: begin
                @(negedge clock);
                check_flag("in_ready", in_ready, 1'b0);
            end
            K_DRAIN: wait_drain();
            default: ;
        endcase
    endtask

    initial begin
        lfsr      = 32'd41;
        m_head    = '0;
        m_tail    = '0;
        exp_alloc = '0;
        isq_cnt   = 0;
        live      = '0;
        done      = '0;
        issued    = '0;
        busy      = '0;
        hold_prev = 1'b0;
        for (int i = 0; i < 64; i++) shadow[i] = '0;
        reset       <= 1'b1;
        in_valid    <= 1'b0;
        in_uop      <= '0;
        int_wb      <= '0;
        mem_wb      <= '0;
        flush_valid <= 1'b0;
        flush_robid <= '0;
        issue_ready <= 1'b1;
        build_table();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag("issue_valid", issue_valid, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        run_step('{kind: K_DRAIN, rdy: 1'b1, default: '0});
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+sim
design/isu_cfg_pkg.sv
design/isu_uop_pkg.sv
design/dispatch.sv
design/rob.sv
design/busy_table.sv
design/int_isq.sv
design/pregfile.sv
design/isu_top.sv
sim/tb_isu_top.sv
